/* src/mtx_pkg.sv */
package mtx_pkg;

   // pin width code as driven on iowidth
   typedef enum logic [1:0] {
      MTX_W8  = 2'd0,   // 8 pins
      MTX_W16 = 2'd1,   // 16 pins
      MTX_W32 = 2'd2,   // 32 pins
      MTX_W64 = 2'd3    // 64 pins
   } mtx_width_e;

   localparam int MTX_PKT_BYTES = 8;                  // bytes per packet word
   localparam int MTX_PKT_BITS  = MTX_PKT_BYTES * 8;  // packet word width

   // bytes on the pins in one clock phase
   function automatic int mtx_pin_bytes(input mtx_width_e w);
      return 1 << w;
   endfunction

   // bytes moved per clock, doubled in ddr
   function automatic int mtx_chunk_bytes(input mtx_width_e w, input logic ddr);
      int bytes;
      bytes = mtx_pin_bytes(w);
      if (ddr) begin
         bytes = bytes * 2;
      end
      // ddr at 64 pins would overflow the packet word
      if (bytes > MTX_PKT_BYTES) begin
         bytes = MTX_PKT_BYTES;
      end
      return bytes;
   endfunction

endpackage

/* src/mtx_sync.sv */
`timescale 1ns/1ps

module mtx_sync (
   input  logic io_clk,
   input  logic nreset,      // raw async reset, active low
   input  logic tx_wait,     // far-side wait, async to io_clk
   output logic io_nreset,   // reset synced to io_clk
   output logic wait_sync    // wait synced to io_clk
);

   logic [1:0] rst_pipe;   // reset sync flops
   logic [1:0] wait_pipe;  // data sync flops

   // ####################
   // reset synchronizer
   // ####################

   // asserts at once, releases two edges after nreset rises
   always_ff @(posedge io_clk or negedge nreset) begin
      if (!nreset) begin
         rst_pipe <= 2'b00;
      end else begin
         rst_pipe <= {rst_pipe[0], 1'b1};   // shift in ones
      end
   end

   assign io_nreset = rst_pipe[1];

   // ####################
   // wait synchronizer
   // ####################

   // plain two-flop sync, cleared by the synced reset
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         wait_pipe <= 2'b00;
      end else begin
         wait_pipe <= {wait_pipe[0], tx_wait};
      end
   end

   assign wait_sync = wait_pipe[1];   // two clocks behind tx_wait

endmodule

/* src/mtx_credit_fifo.sv */
`timescale 1ns/1ps

module mtx_credit_fifo import mtx_pkg::*; #(
   parameter int FIFO_DEPTH = 4   // entries, also the initial core credits
) (
   input  logic                     io_clk,
   input  logic                     io_nreset,
   // core side
   input  logic                     core_valid,   // one packet per cycle high
   input  logic [MTX_PKT_BITS-1:0]  core_data,
   input  logic [MTX_PKT_BYTES-1:0] core_be,      // contiguous from bit 0
   output logic                     core_credit,  // one pulse per packet popped
   // serializer side
   output logic [MTX_PKT_BYTES-1:0] pkt_valid,    // head byte enables, zero if empty
   output logic [MTX_PKT_BITS-1:0]  pkt_data,     // head packet word
   input  logic                     pkt_wait      // serializer not taking
);

   // pointer width, at least one bit
   localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

   // ####################
   // storage
   // ####################

   logic [MTX_PKT_BITS-1:0]  data_mem [FIFO_DEPTH];   // packet words
   logic [MTX_PKT_BYTES-1:0] be_mem   [FIFO_DEPTH];   // byte enables

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;      // entries held, 0..FIFO_DEPTH
   logic          empty;
   logic          push;
   logic          pop;

   // circular increment
   function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
      if (ptr == AW'(FIFO_DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign empty = (count == '0);
   assign push  = core_valid;               // credits keep this from overflowing
   assign pop   = ~pkt_wait & (|pkt_valid); // serializer took the head

   // write side, no reset on payload
   always_ff @(posedge io_clk) begin
      if (push) begin
         data_mem[wr_ptr] <= core_data;
         be_mem[wr_ptr]   <= core_be;
      end
   end

   // ####################
   // pointers and count
   // ####################

   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         wr_ptr <= '0;
      end else if (push) begin
         wr_ptr <= ptr_inc(wr_ptr);
      end
   end

   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         rd_ptr <= '0;
      end else if (pop) begin
         rd_ptr <= ptr_inc(rd_ptr);
      end
   end

   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         count <= '0;
      end else begin
         case ({push, pop})
            2'b10:   count <= count + 1'b1;   // write only
            2'b01:   count <= count - 1'b1;   // read only
            default: count <= count;          // both or neither
         endcase
      end
   end

   // ####################
   // head and credits
   // ####################

   // head entry shown directly, masked off when empty
   assign pkt_valid = empty ? '0 : be_mem[rd_ptr];
   assign pkt_data  = data_mem[rd_ptr];

   // credit goes back the cycle after the pop
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         core_credit <= 1'b0;
      end else begin
         core_credit <= pop;
      end
   end

endmodule

/* src/mtx_oddr.sv */
`timescale 1ns/1ps

module mtx_oddr #(
   parameter int DW = 32   // data width per phase
) (
   input  logic          clk,
   input  logic [DW-1:0] din1,   // even half, high phase
   input  logic [DW-1:0] din2,   // odd half, low phase
   output logic [DW-1:0] out
);

   logic [DW-1:0] q1;       // even, rising edge
   logic [DW-1:0] q2;       // odd, rising edge
   logic [DW-1:0] q2_neg;   // odd, held over the low phase

   // both halves captured together
   always_ff @(posedge clk) begin
      q1 <= din1;
      q2 <= din2;
   end

   // retime odd half so it is stable through the low phase
   always_ff @(negedge clk) begin
      q2_neg <= q2;
   end

   // phase mux
   assign out = clk ? q1 : q2_neg;

endmodule

/* src/mtx_io.sv */
`timescale 1ns/1ps

module mtx_io import mtx_pkg::*; #(
   parameter int IOW = 64   // pin bus width
) (
   input  logic                     io_clk,
   input  logic                     io_nreset,
   input  logic                     ddr_mode,    // two chunks per clock
   input  mtx_width_e               iowidth,     // active pin width
   input  logic                     wait_sync,   // far-side wait, synced
   // packet buffer side
   input  logic [MTX_PKT_BYTES-1:0] pkt_valid,   // byte enables of head packet
   input  logic [MTX_PKT_BITS-1:0]  pkt_data,
   output logic                     pkt_wait,    // no load this cycle
   // pins
   output logic [IOW-1:0]           tx_packet,
   output logic                     tx_access    // frames pin data
);

   localparam int HW = IOW / 2;   // ddr half width

   logic [3:0]               chunk_bytes;   // bytes per clock
   logic [6:0]               chunk_bits;
   logic [6:0]               pin_bits;      // bits per phase
   logic [MTX_PKT_BYTES-1:0] valid_reg;
   logic [MTX_PKT_BYTES-1:0] valid_next;
   logic                     transfer_active;
   logic                     reload;
   logic                     load;
   logic [MTX_PKT_BITS-1:0]  shiftreg;
   logic [MTX_PKT_BITS-1:0]  chunk_hi;      // shiftreg with even half dropped
   logic [IOW-1:0]           tx_packet_sdr;
   logic [HW-1:0]            pin_mask;
   logic [HW-1:0]            ddr_even;
   logic [HW-1:0]            ddr_odd;
   logic [HW-1:0]            tx_packet_ddr;

   assign chunk_bytes = 4'(mtx_chunk_bytes(iowidth, ddr_mode));
   assign chunk_bits  = {chunk_bytes, 3'b000};
   assign pin_bits    = 7'(mtx_pin_bytes(iowidth) * 8);

   // ####################
   // state machine
   // ####################

   // valid bytes left after this clock's chunk
   assign valid_next = valid_reg >> chunk_bytes;

   assign transfer_active = |valid_reg;
   assign reload = ~transfer_active | (valid_next == '0);   // empty now or after this chunk
   assign load   = reload & ~wait_sync;                     // hold off new packets on wait
   assign pkt_wait = ~load;

   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         valid_reg <= '0;
      end else if (load) begin
         valid_reg <= pkt_valid;   // zero if buffer empty
      end else begin
         valid_reg <= valid_next;  // drains to zero under wait
      end
   end

   // access follows valid by one stage, same as the data
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         tx_access <= 1'b0;
      end else begin
         tx_access <= transfer_active;
      end
   end

   // ####################
   // shift register
   // ####################

   // low chunk always in the bottom bits
   always_ff @(posedge io_clk) begin
      if (load) begin
         shiftreg <= pkt_data;
      end else begin
         shiftreg <= shiftreg >> chunk_bits;
      end
   end

   // ####################
   // output stage
   // ####################

   // sdr pipeline stage
   always_ff @(posedge io_clk) begin
      tx_packet_sdr <= shiftreg[IOW-1:0];
   end

   // only the active pins carry data in ddr
   assign pin_mask = ~({HW{1'b1}} << pin_bits);

   assign chunk_hi = shiftreg >> pin_bits;        // upper half of this chunk
   assign ddr_even = shiftreg[HW-1:0] & pin_mask; // first on the pins
   assign ddr_odd  = chunk_hi[HW-1:0] & pin_mask;

   mtx_oddr #(
      .DW (HW)
   ) u_oddr (
      .clk  (io_clk),
      .din1 (ddr_even),
      .din2 (ddr_odd),
      .out  (tx_packet_ddr)
   );

   // ddr drives the lower half of the bus only
   assign tx_packet = ddr_mode ? {{(IOW - HW){1'b0}}, tx_packet_ddr} : tx_packet_sdr;

endmodule

/* src/mtx_top.sv */
`timescale 1ns/1ps

module mtx_top import mtx_pkg::*; #(
   parameter int IOW        = 64,   // pin bus width
   parameter int FIFO_DEPTH = 4     // buffer depth and core credits
) (
   input  logic                     io_clk,
   input  logic                     nreset,       // async, active low
   input  logic                     ddr_mode,
   input  mtx_width_e               iowidth,
   // core interface
   input  logic                     core_valid,
   input  logic [MTX_PKT_BITS-1:0]  core_data,
   input  logic [MTX_PKT_BYTES-1:0] core_be,
   output logic                     core_credit,
   // pins
   output logic [IOW-1:0]           tx_packet,
   output logic                     tx_access,
   input  logic                     tx_wait       // from far side, async
);

   logic                     io_nreset;   // synced reset
   logic                     wait_sync;   // synced far-side wait
   logic [MTX_PKT_BYTES-1:0] pkt_valid;
   logic [MTX_PKT_BITS-1:0]  pkt_data;
   logic                     pkt_wait;

   // reset and wait into io_clk
   mtx_sync u_sync (
      .io_clk    (io_clk),
      .nreset    (nreset),
      .tx_wait   (tx_wait),
      .io_nreset (io_nreset),
      .wait_sync (wait_sync)
   );

   // ####################
   // core side buffer
   // ####################

   mtx_credit_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .io_clk      (io_clk),
      .io_nreset   (io_nreset),
      .core_valid  (core_valid),
      .core_data   (core_data),
      .core_be     (core_be),
      .core_credit (core_credit),
      .pkt_valid   (pkt_valid),
      .pkt_data    (pkt_data),
      .pkt_wait    (pkt_wait)
   );

   // ####################
   // serializer
   // ####################

   mtx_io #(
      .IOW (IOW)
   ) u_io (
      .io_clk    (io_clk),
      .io_nreset (io_nreset),
      .ddr_mode  (ddr_mode),
      .iowidth   (iowidth),
      .wait_sync (wait_sync),
      .pkt_valid (pkt_valid),
      .pkt_data  (pkt_data),
      .pkt_wait  (pkt_wait),
      .tx_packet (tx_packet),
      .tx_access (tx_access)
   );

endmodule

/* dv/mtx_checker.sv */
`timescale 1ns/1ps

module mtx_checker import mtx_pkg::*; (
   input  logic       io_clk,
   input  logic       ddr_mode,
   input  mtx_width_e iowidth,
   input  logic [63:0] tx_packet,
   input  logic       tx_access
);

   logic [7:0] exp_bytes [$];   // expected byte stream, low byte first
   int         exp_lens  [$];   // valid bytes per packet, in order
   int         remaining = 0;   // bytes left in the packet on the pins
   int         errs      = 0;

   // ####################
   // expected data in
   // ####################

   task automatic add_byte(input logic [7:0] b);
      exp_bytes.push_back(b);
   endtask

   task automatic add_len(input int n);
      exp_lens.push_back(n);
   endtask

   // drop everything in flight, used around a reset
   task automatic flush();
      exp_bytes.delete();
      exp_lens.delete();
      remaining = 0;
   endtask

   function automatic int pending();
      return exp_bytes.size();
   endfunction

   // ####################
   // one pin phase
   // ####################

   // start_ok is low on the odd ddr phase, a packet never starts there
   task automatic take_phase(input logic [63:0] pins, input bit start_ok);
      int         pb;
      logic [7:0] exp;
      pb = 1 << int'(iowidth);   // bytes on the pins per phase
      if (remaining == 0 && start_ok) begin
         if (exp_lens.size() == 0) begin
            $display("Error at %0t ns: tx_access high with no packet expected", $time);
            errs++;
            return;
         end
         remaining = exp_lens.pop_front();
      end
      for (int i = 0; i < pb; i++) begin
         if (remaining > 0) begin   // bytes past the packet end are don't care
            exp = exp_bytes.pop_front();
            if (pins[8*i +: 8] !== exp) begin
               $display("Error at %0t ns: expected byte %02h, got %02h",
                        $time, exp, pins[8*i +: 8]);
               errs++;
            end
            remaining--;
         end
      end
   endtask

   // even half 5 ns into the high phase, odd half 5 ns into the low phase
   always @(posedge io_clk) begin
      #5;
      if (tx_access === 1'b1) begin
         take_phase(tx_packet, 1'b1);
         if (ddr_mode) begin
            @(negedge io_clk);
            #5;
            take_phase(tx_packet, 1'b0);
         end
      end
   end

endmodule

/* dv/mtx_tb.sv */
`timescale 1ns/1ps

module mtx_tb import mtx_pkg::*; ;

   typedef logic [7:0] byte_q_t [$];

   localparam int FIFO_DEPTH = 4;
   localparam int TOTAL_PKTS = 32 + 16 + 24 + 16 + 24 + 12;   // all tests

   logic        io_clk = 1'b0;
   logic        nreset = 1'b0;
   logic        ddr_mode = 1'b0;
   mtx_width_e  iowidth = MTX_W8;
   logic        core_valid = 1'b0;
   logic [63:0] core_data = '0;
   logic [7:0]  core_be = '0;
   logic        tx_wait = 1'b0;
   logic        core_credit;
   logic [63:0] tx_packet;
   logic        tx_access;

   integer seed = 43;
   int     sent = 0;       // packets sent since last reset
   int     returned = 0;   // credit pulses since last reset
   int     tb_errs = 0;
   int     errs_mark = 0;
   int     n_pass = 0;
   int     n_fail = 0;

   always #10 io_clk = ~io_clk;   // 20 ns period

   mtx_top #(.IOW(64), .FIFO_DEPTH(FIFO_DEPTH)) UUT (
      .io_clk(io_clk), .nreset(nreset), .ddr_mode(ddr_mode), .iowidth(iowidth),
      .core_valid(core_valid), .core_data(core_data), .core_be(core_be),
      .core_credit(core_credit), .tx_packet(tx_packet), .tx_access(tx_access),
      .tx_wait(tx_wait)
   );

   mtx_checker chk (
      .io_clk(io_clk), .ddr_mode(ddr_mode), .iowidth(iowidth),
      .tx_packet(tx_packet), .tx_access(tx_access)
   );

   // credit pulses back from the buffer
   always @(posedge io_clk or negedge nreset) begin
      if (!nreset) returned <= 0;
      else if (core_credit) returned <= returned + 1;
   end

   function automatic int credits();
      return FIFO_DEPTH - sent + returned;
   endfunction

   // reference: valid bytes of a packet, low byte first
   function automatic byte_q_t expand_packet(input logic [63:0] data, input logic [7:0] be);
      byte_q_t q;
      for (int i = 0; i < 8; i++) begin
         if (be[i]) q.push_back(data[8*i +: 8]);
      end
      return q;
   endfunction

   // ####################
   // stimulus
   // ####################

   task automatic send_packet(input int nbytes);
      byte_q_t q;
      logic [63:0] d;
      d = {$random(seed), $random(seed)};
      while (credits() <= 0) @(negedge io_clk);   // stall until a credit is back
      core_valid = 1'b1;
      core_data  = d;
      core_be    = 8'((9'd1 << nbytes) - 9'd1);
      q = expand_packet(d, core_be);
      chk.add_len(q.size());
      foreach (q[i]) chk.add_byte(q[i]);
      sent++;
      // this packet's credit cannot be back yet
      if (credits() >= FIFO_DEPTH) begin
         $display("Error at %0t ns: credit pulses outnumber the packets sent", $time);
         tb_errs++;
      end
      @(negedge io_clk);
      core_valid = 1'b0;
   endtask

   task automatic send_burst(input int n, input bit partial);
      repeat (n) send_packet(partial ? 1 + ($unsigned($random(seed)) % 8) : 8);
   endtask

   task automatic set_mode(input int w, input bit ddr);
      iowidth  = mtx_width_e'(w);
      ddr_mode = ddr;
   endtask

   // held long enough for the packet in flight to finish first
   task automatic wait_pulse(input int w);
      tx_wait = 1'b1;
      for (int c = 0; c < w; c++) begin
         @(negedge io_clk);
         if (c >= 6 && tx_access !== 1'b0) begin   // sync delay plus a 4 cycle packet
            $display("Error at %0t ns: tx_access high while the far side held wait",
                     $time);
            tb_errs++;
         end
      end
      tx_wait = 1'b0;
   endtask

   // waits for the checker to empty, then checks the credit balance
   task automatic drain();
      while (chk.pending() != 0 || tx_access) @(negedge io_clk);
      repeat (3) @(negedge io_clk);
      if (credits() != FIFO_DEPTH || returned != sent) begin
         $display("Error at %0t ns: credits not restored: %0d held, %0d pulses for %0d packets",
                  $time, credits(), returned, sent);
         tb_errs++;
      end
   endtask

   task automatic end_test(input string name);
      int e;
      e = chk.errs + tb_errs - errs_mark;
      errs_mark = chk.errs + tb_errs;
      if (e == 0) n_pass++;
      else n_fail++;
      $display("%s: %s (%0d errors)", name, (e == 0) ? "ok" : "FAIL", e);
   endtask

   // ####################
   // test sequence
   // ####################

   initial begin
      repeat (5) @(negedge io_clk);
      nreset = 1'b1;
      repeat (3) @(negedge io_clk);   // synced reset releases

      for (int w = 0; w < 4; w++) begin   // sdr, full packets
         set_mode(w, 1'b0);
         send_burst(8, 1'b0);
         drain();
      end
      end_test("sdr full packets");

      for (int w = 1; w < 3; w++) begin
         set_mode(w, 1'b0);
         send_burst(8, 1'b1);
         drain();
      end
      end_test("sdr partial packets");

      for (int w = 0; w < 3; w++) begin   // no ddr at 64 pins
         set_mode(w, 1'b1);
         send_burst(8, 1'b1);
         drain();
      end
      end_test("ddr");

      set_mode(1, 1'b0);   // slow enough to run out of credits
      send_burst(16, 1'b0);
      drain();
      end_test("credit flow");

      for (int r = 0; r < 3; r++) begin
         set_mode(1 + ($unsigned($random(seed)) % 2), $random(seed) % 2 != 0);
         fork
            send_burst(8, 1'b1);
            repeat (2) begin
               repeat (3 + ($unsigned($random(seed)) % 6)) @(negedge io_clk);
               wait_pulse(12 + ($unsigned($random(seed)) % 8));
            end
         join
         drain();
      end
      end_test("far-side wait");

      set_mode(0, 1'b0);
      send_burst(4, 1'b0);
      repeat (6) @(negedge io_clk);
      nreset = 1'b0;   // mid packet
      #2;
      if (tx_access !== 1'b0 || core_credit !== 1'b0) begin
         $display("Error at %0t ns: tx_access or core_credit still high in reset", $time);
         tb_errs++;
      end
      chk.flush();
      sent = 0;
      repeat (5) @(negedge io_clk);
      nreset = 1'b1;
      repeat (3) @(negedge io_clk);
      send_burst(8, 1'b1);
      drain();
      end_test("reset during traffic");

      $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
      if (n_fail == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   // watchdog, sized from the packet count
   initial begin
      #(TOTAL_PKTS * 8 * 20 + 2000);
      $display("timeout: traffic did not drain in time");
      $display("sim failed");
      $finish;
   end

endmodule

/* mtx_top.f */
src/mtx_pkg.sv
src/mtx_sync.sv
src/mtx_credit_fifo.sv
src/mtx_oddr.sv
src/mtx_io.sv
src/mtx_top.sv
dv/mtx_checker.sv
dv/mtx_tb.sv

/* run_sim.sh */
#!/bin/bash
# build the testbench with verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f mtx_top.f --top-module mtx_tb -o mtx_sim \
   && ./obj_dir/mtx_sim | tee /dev/stderr | grep -qx "sim passed" \
   && echo "run_sim: simulation passed" \
   || { echo "run_sim: simulation failed"; exit 1; }
